// File: build.f
hdl/mips_pkg.sv
hdl/controller.sv
hdl/alu.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/mem_access.sv
hdl/mips_top.sv
sim/tb_mips.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - hdl/mips_pkg.sv
  - hdl/controller.sv
  - hdl/alu.sv
  - hdl/register_file.sv
  - hdl/fetch_unit.sv
  - hdl/mem_access.sv
  - hdl/mips_top.sv
  - target: simulation
    files:
      - sim/tb_mips.sv

// File: sim/tb_mips.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips
    import mips_pkg::*;
();

    localparam logic [31:0] RESET_PC = 32'h0000_0200;
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] st_adr [$];   // Stores seen on the bus.
    logic [31:0] st_dat [$];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [31:0] pc_ptr;
    logic [15:0] store_off;
    int          marker;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    integer      seed;
    bit          busy;
    int          wait_left;
    wb_req_t     held_req;
    logic [31:0] held_pc;
    logic [31:0] prev_pc;

    mips_top #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    always #10 clk = ~clk;

    always @(negedge clk)
        imem_data <= imem[imem_addr[9:2]];

    // Wishbone slave with 0 to 3 wait states.
    always @(negedge clk)
    begin
        if (!rst_n || !(wb_req.cyc && wb_req.stb))
        begin
            if (rst_n && busy)
                check_value("imem_addr", imem_addr, held_pc + 32'd4); // Advanced at ack.
            wb_rsp <= '0;
            busy = 1'b0;
        end
        else
        begin
            if (!busy)
            begin
                busy = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
                held_req = wb_req;
                held_pc = prev_pc; // Memory instruction seen a cycle before cyc.
            end
            check_value("wb_req.adr", wb_req.adr, held_req.adr);
            check_value("wb_req.dat", wb_req.dat, held_req.dat);
            check_value("wb_req.we", wb_req.we, held_req.we);
            check_value("wb_req.sel", wb_req.sel, 4'hf);
            check_value("imem_addr", imem_addr, held_pc); // PC held during the stall.
            if (wait_left > 0)
            begin
                wait_left--;
                wb_rsp <= '0;
            end
            else if (wb_req.we)
            begin
                dmem[wb_req.adr[7:0]] = wb_req.dat;
                st_adr.push_back({wb_req.adr, 2'b00});
                st_dat.push_back(wb_req.dat);
                wb_rsp <= '{ack: 1'b1, dat: 32'h0};
            end
            else
                wb_rsp <= '{ack: 1'b1, dat: dmem[wb_req.adr[7:0]]};
        end
        prev_pc = imem_addr;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'ha5, ~idx, idx, idx ^ 8'h3c};
    endfunction

    function automatic logic [31:0] rtype(input funct_e fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype(input opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input opcode_e op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(input logic [31:0] instr);
        imem[pc_ptr[9:2]] = instr;
        pc_ptr = pc_ptr + 32'd4;
    endtask

    task automatic expect_store(input logic [31:0] adr, input logic [31:0] dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    task automatic load_const(input logic [4:0] r, input logic [31:0] value);
        emit(itype(OP_LUI, 0, r, value[31:16]));
        emit(itype(OP_ORI, r, r, value[15:0]));
    endtask

    // Result goes to r4, then to the next slot above r10.
    task automatic store_result(input logic [31:0] instr, input logic [31:0] exp);
        emit(instr);
        emit(itype(OP_SW, 10, 4, store_off));
        expect_store(32'h100 + store_off, exp);
        store_off += 16'd4;
    endtask

    task automatic branch_case(input opcode_e op, input logic [4:0] rs,
                               input logic [4:0] rt, input bit taken);
        marker++;
        emit(itype(OP_ADDIU, 0, 4, 16'h0100 + 16'(marker)));
        emit(itype(op, rs, rt, 16'd1)); // Skips one instruction.
        emit(itype(OP_ADDIU, 0, 4, 16'h0200 + 16'(marker)));
        emit(itype(OP_SW, 10, 4, store_off));
        expect_store(32'h100 + store_off, taken ? 32'h100 + marker : 32'h200 + marker);
        store_off += 16'd4;
    endtask

    task automatic start_program();
        int i;
        @(negedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < 256; i++)
            imem[i] = 32'h0;
        exp_adr.delete();
        exp_dat.delete();
        pc_ptr = RESET_PC;
        store_off = 16'h0040;
        marker = 0;
        emit(itype(OP_ORI, 0, 10, 16'h0100)); // Base pointer.
    endtask

    task automatic run_program(input string name);
        int          i;
        int          n;
        int          first_errors;
        logic [31:0] a;
        logic [31:0] d;
        first_errors = errors;
        emit(itype(OP_BEQ, 0, 0, 16'hffff)); // Halt loop.
        for (i = 0; i < 256; i++)
            dmem[i] = fill_word(8'(i));
        st_adr.delete();
        st_dat.delete();
        repeat (4) @(negedge clk);
        check_value("imem_addr", imem_addr, RESET_PC);
        check_value("wb_req.cyc", wb_req.cyc, 1'b0);
        check_value("wb_req.stb", wb_req.stb, 1'b0);
        check_value("wb_req.we", wb_req.we, 1'b0);
        rst_n <= 1'b1;
        while (exp_adr.size() > 0)
        begin
            a = exp_adr.pop_front();
            d = exp_dat.pop_front();
            for (n = 0; n < TIMEOUT && st_adr.size() == 0; n++)
                @(posedge clk);
            assert (st_adr.size() > 0)
            else
            begin
                $display("Timeout in %s: no store to %h appeared on the bus", name, a);
                errors++;
            end
            if (st_adr.size() > 0)
            begin
                check_value("wb_req.adr", st_adr.pop_front(), a);
                check_value("wb_req.dat", st_dat.pop_front(), d);
            end
        end
        repeat (20) @(posedge clk);
        assert (st_adr.size() == 0)
        else
        begin
            $display("Unexpected store to %h in %s", st_adr[0], name);
            errors++;
        end
        if (errors == first_errors)
        begin
            tests_passed++;
            $display("%s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - first_errors);
        end
    endtask

    task automatic test_reset();
        start_program();
        run_program("reset");
    endtask

    task automatic test_rtype();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'h8765_4321;
        b = 32'h1234_00f5;
        start_program();
        load_const(1, a);
        load_const(2, b);
        emit(itype(OP_ORI, 0, 3, 16'd5));
        store_result(rtype(FN_ADD, 1, 2, 4, 0), a + b);
        store_result(rtype(FN_ADDU, 1, 2, 4, 0), a + b);
        store_result(rtype(FN_SUB, 1, 2, 4, 0), a - b);
        store_result(rtype(FN_SUBU, 2, 1, 4, 0), b - a);
        store_result(rtype(FN_AND, 1, 2, 4, 0), a & b);
        store_result(rtype(FN_OR, 1, 2, 4, 0), a | b);
        store_result(rtype(FN_XOR, 1, 2, 4, 0), a ^ b);
        store_result(rtype(FN_NOR, 1, 2, 4, 0), ~(a | b));
        store_result(rtype(FN_SLT, 1, 2, 4, 0), 32'd1); // a is negative.
        store_result(rtype(FN_SLT, 2, 1, 4, 0), 32'd0);
        store_result(rtype(FN_SLL, 0, 2, 4, 4), b << 4);
        store_result(rtype(FN_SRL, 0, 1, 4, 8), a >> 8);
        store_result(rtype(FN_SRA, 0, 1, 4, 8), {{8{a[31]}}, a[31:8]});
        store_result(rtype(FN_SLLV, 3, 2, 4, 0), b << 5);
        store_result(rtype(FN_SRLV, 3, 1, 4, 0), a >> 5);
        run_program("R-type");
    endtask

    task automatic test_immediate();
        logic [31:0] a;
        a = 32'h8765_4321;
        start_program();
        load_const(1, a);
        emit(itype(OP_ORI, 0, 2, 16'h1234));
        store_result(itype(OP_ADDI, 0, 4, 16'hfffb), 32'hffff_fffb);
        store_result(itype(OP_ADDI, 1, 4, 16'h8000), a + 32'hffff_8000);
        store_result(itype(OP_ADDIU, 2, 4, 16'h7fff), 32'h1234 + 32'h7fff);
        store_result(itype(OP_ANDI, 1, 4, 16'hf0f0), a & 32'h0000_f0f0);
        store_result(itype(OP_ORI, 1, 4, 16'h8000), a | 32'h0000_8000);
        store_result(itype(OP_XORI, 1, 4, 16'hffff), a ^ 32'h0000_ffff);
        store_result(itype(OP_SLTI, 1, 4, 16'hffff), 32'd1);
        store_result(itype(OP_SLTI, 2, 4, 16'hffff), 32'd0);
        store_result(itype(OP_SLTI, 2, 4, 16'h2000), 32'd1);
        store_result(itype(OP_LUI, 0, 4, 16'hbeef), 32'hbeef_0000);
        run_program("immediate");
    endtask

    task automatic test_loads();
        start_program();
        emit(itype(OP_LW, 10, 5, 16'h0000));
        emit(itype(OP_LW, 10, 6, 16'h0004));
        emit(itype(OP_LW, 10, 8, 16'hfffc));
        store_result(itype(OP_ADDIU, 5, 4, 16'd1), fill_word(8'd64) + 32'd1);
        store_result(rtype(FN_XOR, 5, 6, 4, 0), fill_word(8'd64) ^ fill_word(8'd65));
        store_result(rtype(FN_ADDU, 8, 0, 4, 0), fill_word(8'd63));
        emit(itype(OP_LW, 10, 7, 16'h0040)); // Reads back the first store.
        store_result(itype(OP_ADDIU, 7, 4, 16'd2), fill_word(8'd64) + 32'd3);
        run_program("loads");
    endtask

    task automatic test_branches();
        start_program();
        load_const(1, 32'h8765_4321);
        emit(itype(OP_ORI, 0, 2, 16'h1234));
        emit(itype(OP_ORI, 0, 3, 16'd5));
        emit(itype(OP_ORI, 0, 6, 16'd5));
        branch_case(OP_BEQ, 3, 6, 1'b1);
        branch_case(OP_BEQ, 3, 2, 1'b0);
        branch_case(OP_BNE, 3, 2, 1'b1);
        branch_case(OP_BNE, 3, 6, 1'b0);
        branch_case(OP_BLEZ, 1, 0, 1'b1);
        branch_case(OP_BLEZ, 0, 0, 1'b1);
        branch_case(OP_BLEZ, 3, 0, 1'b0);
        branch_case(OP_BGTZ, 3, 0, 1'b1);
        branch_case(OP_BGTZ, 0, 0, 1'b0);
        branch_case(OP_BGTZ, 1, 0, 1'b0);
        branch_case(OP_BGEZ, 0, 1, 1'b1);
        branch_case(OP_BGEZ, 1, 1, 1'b0);
        branch_case(OP_BGEZ, 3, 1, 1'b1);
        run_program("branches");
    endtask

    // Subroutine at +0x24 stores r31, then jr returns to +0x08.
    task automatic test_jumps();
        start_program();
        emit(jtype(OP_JAL, RESET_PC + 32'h24));
        emit(itype(OP_SW, 10, 31, 16'h0040));
        emit(jtype(OP_J, RESET_PC + 32'h18));
        emit(itype(OP_ADDIU, 0, 4, 16'h0bad));
        emit(itype(OP_SW, 10, 4, 16'h0044));
        emit(itype(OP_ADDIU, 0, 4, 16'h0077));
        emit(itype(OP_SW, 10, 4, 16'h0044));
        emit(itype(OP_BEQ, 0, 0, 16'hffff));
        emit(itype(OP_SW, 10, 31, 16'h0048));
        emit(rtype(FN_JR, 31, 0, 0, 0));
        expect_store(32'h148, RESET_PC + 32'h08);
        expect_store(32'h140, RESET_PC + 32'h08);
        expect_store(32'h144, 32'h77);
        run_program("jumps");
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        imem_data = 32'h0;
        wb_rsp = '0;
        seed = 32'ha283;
        busy = 1'b0;
        wait_left = 0;
        prev_pc = 32'h0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_reset();
        test_rtype();
        test_immediate();
        test_loads();
        test_branches();
        test_jumps();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/mips_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_top
    import mips_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp
);

    ctrl_t       ctrl;
    opcode_e     opcode;
    funct_e      func;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [31:0] imm_ext;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        cond;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] load_data;
    logic        stall;
    logic [4:0]  dest;
    logic [31:0] wb_data;

    assign opcode = opcode_e'(imem_data[31:26]);
    assign func = funct_e'(imem_data[5:0]);
    assign rs = imem_data[25:21];
    assign rt = imem_data[20:16];
    assign rd = imem_data[15:11];
    assign imm = imem_data[15:0];
    assign imem_addr = pc;

    controller u_controller (
        .opcode (opcode),
        .func   (func),
        .ctrl   (ctrl)
    );

    // lui goes to the upper half, logic ops zero extend.
    always_comb
    begin
        if (ctrl.alu_op == ALU_LUI)
            imm_ext = {imm, 16'b0};
        else if (ctrl.imm_zero_ext)
            imm_ext = {16'b0, imm};
        else
            imm_ext = {{16{imm[15]}}, imm};
    end

    assign alu_b = ctrl.alu_src ? imm_ext : rt_data;
    assign dest = ctrl.link ? 5'd31 : (ctrl.reg_dst ? rd : rt);
    assign wb_data = ctrl.link       ? pc_plus4  :
                     ctrl.mem_to_reg ? load_data : alu_result;

    register_file u_register_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs),
        .ra2   (rt),
        .wa    (dest),
        .we    (ctrl.reg_write && !stall), // Loads write on ack only.
        .wd    (wb_data),
        .rd1   (rs_data),
        .rd2   (rt_data)
    );

    alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (imem_data[10:6]),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .cond   (cond)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .ctrl     (ctrl),
        .cond     (cond),
        .rs_data  (rs_data),
        .instr    (imem_data),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    mem_access u_mem_access (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .addr   (alu_result),
        .wdata  (rt_data),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .stall  (stall),
        .rdata  (load_data)
    );

endmodule

`default_nettype wire

// File: hdl/mem_access.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  ctrl_t       ctrl,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp,
    output logic        stall,
    output logic [31:0] rdata
);

    typedef enum logic {
        IDLE,
        BUS
    } state_e;

    state_e      state;
    logic        mem_op;
    logic        req_we;
    logic [29:0] req_adr;
    logic [31:0] req_dat;

    assign mem_op = ctrl.mem_read | ctrl.mem_write;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            req_we <= 1'b0;
        end
        else if (state == IDLE && mem_op)
        begin
            state <= BUS;
            req_we <= ctrl.mem_write;
        end
        else if (state == BUS && wb_rsp.ack)
        begin
            state <= IDLE; // cyc drops the cycle after ack.
            req_we <= 1'b0;
        end
    end

    // Address and data stay fixed for the whole transfer.
    always_ff @(posedge clk)
    begin
        if (state == IDLE && mem_op)
        begin
            req_adr <= addr[31:2];
            req_dat <= wdata;
        end
    end

    assign wb_req = '{cyc: (state == BUS), stb: (state == BUS), we: req_we,
                      adr: req_adr, dat: req_dat, sel: 4'hf};

    assign stall = mem_op && !(state == BUS && wb_rsp.ack);
    assign rdata = wb_rsp.dat;

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
    import mips_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  ctrl_t       ctrl,
    input  logic        cond,
    input  logic [31:0] rs_data,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic [31:0] pc_plus4
);

    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_pc;

    assign pc_plus4 = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jump_target = {pc_plus4[31:28], instr[25:0], 2'b00};

    always_comb
    begin
        if (ctrl.jump_reg)
            next_pc = rs_data;
        else if (ctrl.jump)
            next_pc = jump_target;
        else if (ctrl.branch && cond)
            next_pc = branch_target;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (!stall) // Hold while the bus is busy.
            pc <= next_pc;
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && wa != 5'd0)
        begin
            regs[wa] <= wd;
        end
    end

    // r0 always reads zero.
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  alu_op_e     op,
    output logic [31:0] result,
    output logic        cond
);

    logic signed [31:0] a_s;
    logic signed [31:0] b_s;

    assign a_s = a;
    assign b_s = b;

    always_comb
    begin
        result = '0;
        case (op)
            ALU_XOR:  result = a ^ b;
            ALU_OR:   result = a | b;
            ALU_NOR:  result = ~(a | b);
            ALU_AND:  result = a & b;
            ALU_ADD:  result = a + b; // No overflow trap.
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {31'b0, a_s < b_s};
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = b_s >>> shamt;
            ALU_SLLV: result = b << a[4:0];
            ALU_SRLV: result = b >> a[4:0];
            ALU_LUI:  result = b; // Already shifted up by the top.
            ALU_PASS: result = a;
            default:  result = '0;
        endcase
    end

    // Branch condition.
    always_comb
    begin
        case (op)
            ALU_EQ:  cond = (a == b);
            ALU_NE:  cond = (a != b);
            ALU_LEZ: cond = (a_s <= 0);
            ALU_GTZ: cond = (a_s > 0);
            ALU_GEZ: cond = (a_s >= 0);
            default: cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller
    import mips_pkg::*;
(
    input  opcode_e opcode,
    input  funct_e  func,
    output ctrl_t   ctrl
);

    always_comb
    begin
        ctrl = '0; // No-operation unless decoded below.
        ctrl.alu_op = ALU_ADD;

        case (opcode)
            OP_RTYPE:
            begin
                ctrl.reg_dst = 1'b1;
                ctrl.reg_write = 1'b1;
                case (func)
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SLLV: ctrl.alu_op = ALU_SLLV;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    FN_SRLV: ctrl.alu_op = ALU_SRLV;
                    FN_SRA:  ctrl.alu_op = ALU_SRA;
                    FN_ADD,
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB,
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR:
                    begin
                        ctrl.alu_op = ALU_PASS;
                        ctrl.jump_reg = 1'b1;
                        ctrl.reg_write = 1'b0;
                    end
                    default:
                    begin
                        // Unknown func behaves as a nop.
                        ctrl.reg_dst = 1'b0;
                        ctrl.reg_write = 1'b0;
                    end
                endcase
            end

            OP_ADDI, OP_ADDIU:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_write = 1'b1;
            end

            OP_ANDI, OP_ORI, OP_XORI:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op = (opcode == OP_ANDI) ? ALU_AND :
                              (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end

            OP_SLTI:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op = ALU_SLT;
            end

            OP_LUI:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op = ALU_LUI;
            end

            OP_LW:
            begin
                ctrl.alu_src = 1'b1; // Address is rs + offset.
                ctrl.mem_read = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write = 1'b1;
            end

            OP_SW:
            begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_write = 1'b1;
            end

            // Branches compare rs with rt or with zero.
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BGEZ:
            begin
                ctrl.branch = 1'b1;
                case (opcode)
                    OP_BEQ:  ctrl.alu_op = ALU_EQ;
                    OP_BNE:  ctrl.alu_op = ALU_NE;
                    OP_BLEZ: ctrl.alu_op = ALU_LEZ;
                    OP_BGTZ: ctrl.alu_op = ALU_GTZ;
                    default: ctrl.alu_op = ALU_GEZ;
                endcase
            end

            OP_J:
                ctrl.jump = 1'b1;

            OP_JAL:
            begin
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.reg_write = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Primary opcodes.
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BGEZ  = 6'b000001,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_BLEZ  = 6'b000110,
        OP_BGTZ  = 6'b000111,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_e;

    // R-type func field.
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_JR   = 6'b001000,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_e;

    typedef enum logic [4:0] {
        ALU_XOR  = 5'b00000,
        ALU_SLL  = 5'b00001,
        ALU_SRL  = 5'b00010,
        ALU_SRA  = 5'b00011,
        ALU_ADD  = 5'b00100,
        ALU_SUB  = 5'b00101,
        ALU_OR   = 5'b01000,
        ALU_NOR  = 5'b01001,
        ALU_AND  = 5'b01010,
        ALU_SLT  = 5'b01011,
        ALU_PASS = 5'b01100, // jr
        ALU_EQ   = 5'b01101,
        ALU_NE   = 5'b01110,
        ALU_LEZ  = 5'b01111,
        ALU_GTZ  = 5'b10000,
        ALU_GEZ  = 5'b10001,
        ALU_LUI  = 5'b10010,
        ALU_SLLV = 5'b11001,
        ALU_SRLV = 5'b11010
    } alu_op_e;

    typedef struct packed {
        logic    reg_dst;      // 1 selects rd, 0 selects rt.
        logic    alu_src;      // Immediate as second operand.
        logic    imm_zero_ext;
        logic    branch;
        logic    jump;
        logic    jump_reg;
        logic    link;         // Write PC+4 into r31.
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    reg_write;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [29:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
